// File: Bender.yml
package:
  name: icache

sources:
  # packages first, then the interface and the RTL modules
  - icache_cfg_pkg.sv
  - icache_mem_pkg.sv
  - icache_array_if.sv
  - icache_ctrl.sv
  - icache_tag_array.sv
  - icache_data_array.sv
  - icache_repl.sv
  - icache_top.sv
  - target: test
    files:
      - tb_icache.sv

// File: icache_array_if.sv
////////////////////////////////////////////////////////////////////////////
// control and status between the cache controller and its datapaths
// all array reads have one cycle of latency
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface icache_array_if;

  // from the controller
  logic                     rden;
  logic                     wren;
  logic                     inv_en;
  logic                     flush_en;
  logic                     lookup_q;
  icache_cfg_pkg::set_idx_t index;
  icache_cfg_pkg::tag_t     tag_q;
  // word within the line
  logic [icache_cfg_pkg::OffsetWidth-3:0] offset_q;

  // from the tag array
  icache_cfg_pkg::way_oh_t  hit_oh;
  icache_cfg_pkg::way_oh_t  vld_rdata;
  logic                     flush_done;

  // from the replacement logic
  icache_cfg_pkg::way_oh_t  victim_oh;
  icache_cfg_pkg::way_idx_t victim_idx;

  modport ctrl (
    output rden, wren, inv_en, flush_en, lookup_q, index, tag_q, offset_q,
    input  hit_oh, flush_done
  );

  modport tag (
    input  rden, wren, inv_en, flush_en, lookup_q, index, tag_q, victim_oh,
    output hit_oh, vld_rdata, flush_done
  );

  modport data (
    input  rden, wren, lookup_q, index, offset_q, hit_oh, victim_oh
  );

  modport repl (
    input  wren, lookup_q, vld_rdata,
    output victim_oh, victim_idx
  );

endinterface

// File: icache_cfg_pkg.sv
////////////////////////////////////////////////////////////////////////////
// fixed geometry of the 4-way, 16-set instruction cache with 128-bit lines
// fetch addresses are physical and assumed 32-bit aligned
////////////////////////////////////////////////////////////////////////////

package icache_cfg_pkg;

  // cache geometry
  localparam int unsigned NumWays     = 4;
  localparam int unsigned NumSets     = 16;
  localparam int unsigned LineWidth   = 128;
  localparam int unsigned FetchWidth  = 32;

  // address split as tag | set index | byte offset
  localparam int unsigned TagWidth    = 24;
  localparam int unsigned IndexWidth  = 4;
  localparam int unsigned OffsetWidth = 4;
  localparam int unsigned WayIdxWidth = 2;

  typedef logic [TagWidth+IndexWidth+OffsetWidth-1:0] addr_t;
  typedef logic [TagWidth-1:0]                        tag_t;
  typedef logic [IndexWidth-1:0]                      set_idx_t;
  typedef logic [WayIdxWidth-1:0]                     way_idx_t;
  // one-hot way select or way mask
  typedef logic [NumWays-1:0]                         way_oh_t;
  typedef logic [LineWidth-1:0]                       line_t;
  typedef logic [FetchWidth-1:0]                      fetch_t;

endpackage

// File: icache_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// cache controller with flush, idle, lookup and miss states
// a flush request during a miss waits for the next idle cycle
// refill returns are consumed unconditionally, one miss at a time
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       en_i,
  input  logic                       flush_i,
  // fetch side
  input  logic                       req_i,
  input  icache_cfg_pkg::addr_t      addr_i,
  output logic                       ready_o,
  output logic                       valid_o,
  output logic                       miss_o,
  output icache_cfg_pkg::addr_t      addr_o,
  // memory side
  output logic                       mem_req_o,
  input  logic                       mem_ack_i,
  output icache_cfg_pkg::addr_t      mem_addr_o,
  output logic                       mem_nc_o,
  input  logic                       mem_rtrn_vld_i,
  input  icache_mem_pkg::rtrn_type_e mem_rtrn_type_i,
  icache_array_if.ctrl               arr
);

  typedef enum logic [1:0] {FLUSH, IDLE, READ, MISS} state_e;

  state_e                state_d, state_q;
  logic                  cache_en_d, cache_en_q;
  logic                  flush_d, flush_q;
  logic                  inv_q;
  logic                  lookup_d, lookup_q;
  logic                  accept;
  icache_cfg_pkg::addr_t addr_q;

  ////////////////////////////////////////////////////////////////////////////
  // address fields and memory request
  ////////////////////////////////////////////////////////////////////////////

  assign accept = ready_o & req_i;

  // a new request addresses the arrays directly from addr_i
  assign arr.index    = accept ? addr_i[icache_cfg_pkg::OffsetWidth +: icache_cfg_pkg::IndexWidth]
                               : addr_q[icache_cfg_pkg::OffsetWidth +: icache_cfg_pkg::IndexWidth];
  assign arr.tag_q    = addr_q[icache_cfg_pkg::OffsetWidth + icache_cfg_pkg::IndexWidth +:
                               icache_cfg_pkg::TagWidth];
  assign arr.offset_q = addr_q[2 +: icache_cfg_pkg::OffsetWidth - 2];
  assign arr.lookup_q = lookup_q;
  assign addr_o       = addr_q;

  // disabled cache fetches one word, enabled cache a full line
  assign mem_nc_o   = ~cache_en_q;
  assign mem_addr_o = mem_nc_o ? (addr_q & ~icache_cfg_pkg::addr_t'(3))
                               : (addr_q & ~icache_cfg_pkg::addr_t'(
                                            icache_cfg_pkg::LineWidth / 8 - 1));

  // invalidations share the return port with refills
  assign arr.inv_en = mem_rtrn_vld_i && (mem_rtrn_type_i == icache_mem_pkg::ICACHE_INV_REQ);

  ////////////////////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    cache_en_d   = cache_en_q;
    // remember flush requests until the next idle
    flush_d      = flush_q | flush_i;
    lookup_d     = 1'b0;
    arr.flush_en = 1'b0;
    arr.rden     = 1'b0;
    arr.wren     = 1'b0;
    ready_o      = 1'b0;
    valid_o      = 1'b0;
    mem_req_o    = 1'b0;
    miss_o       = 1'b0;

    unique case (state_q)
      // clear one set of valid bits per cycle
      FLUSH: begin
        arr.flush_en = 1'b1;
        if (arr.flush_done) begin
          state_d    = IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      IDLE: begin
        // disabling takes effect at once, enabling goes through a flush
        cache_en_d = cache_en_q & en_i;
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d = FLUSH;
        end else if (!mem_rtrn_vld_i) begin
          // an incoming invalidation owns the arrays this cycle
          ready_o = 1'b1;
          if (req_i) begin
            arr.rden = cache_en_d;
            lookup_d = cache_en_d;
            state_d  = READ;
          end
        end
      end
      READ: begin
        if (lookup_q && |arr.hit_oh && !inv_q) begin
          valid_o    = 1'b1;
          state_d    = IDLE;
          cache_en_d = cache_en_q & en_i;
          // back-to-back hit unless a flush or an invalidation intervenes
          if (!mem_rtrn_vld_i && !flush_d) begin
            ready_o = 1'b1;
            if (req_i) begin
              arr.rden = cache_en_d;
              lookup_d = cache_en_d;
              state_d  = READ;
            end
          end
        end else if (lookup_q && inv_q) begin
          // tags were read around an invalidation, look up once more
          arr.rden = 1'b1;
          lookup_d = 1'b1;
        end else begin
          // miss or uncached fetch, hold the request until acknowledged
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = cache_en_q;
            state_d = MISS;
          end
        end
      end
      MISS: begin
        if (mem_rtrn_vld_i && (mem_rtrn_type_i == icache_mem_pkg::ICACHE_IFILL_ACK)) begin
          valid_o  = 1'b1;
          // uncached data is passed on and not stored
          arr.wren = cache_en_q;
          state_d  = IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= FLUSH;
      cache_en_q <= 1'b0;
      flush_q    <= 1'b0;
      inv_q      <= 1'b0;
      lookup_q   <= 1'b0;
    end else begin
      state_q    <= state_d;
      cache_en_q <= cache_en_d;
      flush_q    <= flush_d;
      inv_q      <= arr.inv_en;
      lookup_q   <= lookup_d;
    end
  end

  // fetch address, held for lookup, refill and output
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= addr_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////////////////////

  state_legal_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) state_q inside {FLUSH, IDLE, READ, MISS}
  ) else $error("icache_ctrl: illegal state");

  // a refill and an invalidation never share a return cycle
  wren_inv_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(arr.wren && arr.inv_en)
  ) else $error("icache_ctrl: refill write during invalidation");

endmodule

// File: icache_data_array.sv
////////////////////////////////////////////////////////////////////////////
// line storage per way, read for all ways on every lookup
// outside a lookup the fetch word comes straight from the return port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_data_array (
  input  logic                          clk_i,
  input  icache_mem_pkg::rtrn_payload_u rtrn_i,
  output icache_cfg_pkg::fetch_t        data_o,
  icache_array_if.data                  arr
);

  icache_cfg_pkg::line_t  line_mem [icache_cfg_pkg::NumSets][icache_cfg_pkg::NumWays];
  icache_cfg_pkg::line_t  line_rdata [icache_cfg_pkg::NumWays];
  icache_cfg_pkg::fetch_t hit_word;

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < icache_cfg_pkg::NumWays; w++) begin
      // refill lands in the victim way only
      if (arr.wren && arr.victim_oh[w]) begin
        line_mem[arr.index][w] <= rtrn_i.data;
      end
      if (arr.rden) begin
        line_rdata[w] <= line_mem[arr.index][w];
      end
    end
  end

  // hit_oh is one-hot, so an OR picks the hit way
  always_comb begin
    hit_word = '0;
    for (int w = 0; w < icache_cfg_pkg::NumWays; w++) begin
      if (arr.hit_oh[w]) begin
        hit_word |= line_rdata[w][arr.offset_q * icache_cfg_pkg::FetchWidth +:
                                  icache_cfg_pkg::FetchWidth];
      end
    end
  end

  assign data_o = arr.lookup_q ? hit_word
                               : rtrn_i.data[arr.offset_q * icache_cfg_pkg::FetchWidth +:
                                             icache_cfg_pkg::FetchWidth];

endmodule

// File: icache_mem_pkg.sv
////////////////////////////////////////////////////////////////////////////
// refill request and return port types of the instruction cache
// one return word carries either a full line or an invalidation record
////////////////////////////////////////////////////////////////////////////

package icache_mem_pkg;

  // kind of a return beat, decides how the payload is decoded
  typedef enum logic {
    ICACHE_IFILL_ACK = 1'b0,
    ICACHE_INV_REQ   = 1'b1
  } rtrn_type_e;

  // unused upper bits of an invalidation record
  localparam int unsigned InvPadWidth = icache_cfg_pkg::LineWidth - 2
                                        - icache_cfg_pkg::WayIdxWidth
                                        - icache_cfg_pkg::IndexWidth;

  // invalidation record in the low bits of the return word
  typedef struct packed {
    logic [InvPadWidth-1:0]   pad;
    // clear every way of the set
    logic                     all_ways;
    // clear only the way given in way
    logic                     one_way;
    icache_cfg_pkg::way_idx_t way;
    icache_cfg_pkg::set_idx_t idx;
  } inv_req_t;

  // same 128-bit return word, read as refill data or invalidation
  typedef union packed {
    icache_cfg_pkg::line_t data;
    inv_req_t              inv;
  } rtrn_payload_u;

endpackage

// File: icache_repl.sv
////////////////////////////////////////////////////////////////////////////
// victim choice, lowest invalid way first, else a 4-bit LFSR way
// LfsrSeed must be nonzero
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_repl #(
  parameter logic [3:0] LfsrSeed = 4'h9
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  icache_array_if.repl  arr
);

  logic [3:0]               lfsr_q;
  logic                     all_valid;
  icache_cfg_pkg::way_idx_t inv_way;
  icache_cfg_pkg::way_idx_t victim_d;
  icache_cfg_pkg::way_oh_t  victim_oh_q;

  // lowest-numbered invalid way, scanned from the top down
  always_comb begin
    inv_way = '0;
    for (int w = icache_cfg_pkg::NumWays - 1; w >= 0; w--) begin
      if (!arr.vld_rdata[w]) begin
        inv_way = icache_cfg_pkg::way_idx_t'(w);
      end
    end
  end

  assign all_valid = &arr.vld_rdata;
  assign victim_d  = all_valid ? lfsr_q[icache_cfg_pkg::WayIdxWidth-1:0] : inv_way;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q      <= LfsrSeed;
      victim_oh_q <= '0;
    end else begin
      // x^4 + x^3 + 1, stepped once per refill
      if (arr.wren) begin
        lfsr_q <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};
      end
      // victim follows the valid bits of the set being looked up
      if (arr.lookup_q) begin
        victim_oh_q <= icache_cfg_pkg::way_oh_t'(1) << victim_d;
      end
    end
  end

  always_comb begin
    arr.victim_idx = '0;
    for (int w = 0; w < icache_cfg_pkg::NumWays; w++) begin
      if (victim_oh_q[w]) begin
        arr.victim_idx = icache_cfg_pkg::way_idx_t'(w);
      end
    end
  end

  assign arr.victim_oh = victim_oh_q;

  // valid bits read during a lookup are never X after the flush
  victim_onehot_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) arr.lookup_q |=> $onehot(arr.victim_oh)
  ) else $error("icache_repl: victim way not one-hot");

endmodule

// File: icache_tag_array.sv
////////////////////////////////////////////////////////////////////////////
// tag and valid flip-flop arrays with one cycle read latency
// flush beats invalidation, which beats the lookup index
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_tag_array (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  icache_mem_pkg::rtrn_payload_u rtrn_i,
  icache_array_if.tag                   arr
);

  icache_cfg_pkg::tag_t     tag_mem [icache_cfg_pkg::NumSets][icache_cfg_pkg::NumWays];
  icache_cfg_pkg::way_oh_t  vld_mem [icache_cfg_pkg::NumSets];
  icache_cfg_pkg::tag_t     tag_rdata [icache_cfg_pkg::NumWays];
  icache_cfg_pkg::way_oh_t  vld_rdata_q;
  icache_cfg_pkg::way_oh_t  vld_mask;
  icache_cfg_pkg::way_oh_t  hit;
  icache_cfg_pkg::set_idx_t flush_cnt_q;
  icache_cfg_pkg::set_idx_t vld_addr;
  logic                     vld_we;

  assign vld_addr = arr.flush_en ? flush_cnt_q    :
                    arr.inv_en   ? rtrn_i.inv.idx :
                                   arr.index;

  // ways touched by a valid-bit write
  always_comb begin
    vld_mask = arr.victim_oh;
    if (arr.flush_en) begin
      vld_mask = '1;
    end else if (arr.inv_en) begin
      if (rtrn_i.inv.all_ways) begin
        vld_mask = '1;
      end else if (rtrn_i.inv.one_way) begin
        vld_mask = icache_cfg_pkg::way_oh_t'(1) << rtrn_i.inv.way;
      end else begin
        vld_mask = '0;
      end
    end
  end

  // only a refill sets a valid bit
  assign vld_we = arr.flush_en | arr.inv_en | arr.wren;

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < icache_cfg_pkg::NumWays; w++) begin
      if (vld_we && vld_mask[w]) begin
        vld_mem[vld_addr][w] <= arr.wren;
      end
      if (arr.wren && arr.victim_oh[w]) begin
        tag_mem[vld_addr][w] <= arr.tag_q;
      end
      if (arr.rden) begin
        tag_rdata[w] <= tag_mem[vld_addr][w];
      end
    end
    if (arr.rden) begin
      vld_rdata_q <= vld_mem[vld_addr];
    end
  end

  // walks all sets once, then wraps to zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flush_cnt_q <= '0;
    end else if (arr.flush_en) begin
      flush_cnt_q <= arr.flush_done ? '0 : flush_cnt_q + 1'b1;
    end
  end

  assign arr.flush_done = (flush_cnt_q == icache_cfg_pkg::set_idx_t'(icache_cfg_pkg::NumSets - 1));

  // tag compare, quiet outside of a lookup
  always_comb begin
    for (int w = 0; w < icache_cfg_pkg::NumWays; w++) begin
      hit[w] = arr.lookup_q & vld_rdata_q[w] & (tag_rdata[w] == arr.tag_q);
    end
  end

  assign arr.hit_oh    = hit;
  assign arr.vld_rdata = vld_rdata_q;

  // a line is never allocated twice in one set
  hit_onehot_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) arr.lookup_q |-> $onehot0(arr.hit_oh)
  ) else $error("icache_tag_array: more than one way hit");

endmodule

// File: icache_top.sv
////////////////////////////////////////////////////////////////////////////
// instruction cache top level with plain fetch and memory ports
// mem_rtrn_i cannot be stalled, at most one refill is outstanding
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_top #(
  parameter logic [3:0] LfsrSeed = 4'h9
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          en_i,
  input  logic                          flush_i,
  // fetch side
  input  logic                          req_i,
  input  icache_cfg_pkg::addr_t         addr_i,
  output logic                          ready_o,
  output logic                          valid_o,
  output icache_cfg_pkg::fetch_t        data_o,
  output icache_cfg_pkg::addr_t         addr_o,
  // performance counter
  output logic                          miss_o,
  // refill request
  output logic                          mem_req_o,
  input  logic                          mem_ack_i,
  output icache_cfg_pkg::addr_t         mem_addr_o,
  output logic                          mem_nc_o,
  output icache_cfg_pkg::way_idx_t      mem_way_o,
  // refill and invalidation return
  input  logic                          mem_rtrn_vld_i,
  input  icache_mem_pkg::rtrn_type_e    mem_rtrn_type_i,
  input  icache_mem_pkg::rtrn_payload_u mem_rtrn_i
);

  icache_array_if arr ();

  // way the pending refill will overwrite
  assign mem_way_o = arr.victim_idx;

  icache_ctrl i_ctrl (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .en_i            ( en_i            ),
    .flush_i         ( flush_i         ),
    .req_i           ( req_i           ),
    .addr_i          ( addr_i          ),
    .ready_o         ( ready_o         ),
    .valid_o         ( valid_o         ),
    .miss_o          ( miss_o          ),
    .addr_o          ( addr_o          ),
    .mem_req_o       ( mem_req_o       ),
    .mem_ack_i       ( mem_ack_i       ),
    .mem_addr_o      ( mem_addr_o      ),
    .mem_nc_o        ( mem_nc_o        ),
    .mem_rtrn_vld_i  ( mem_rtrn_vld_i  ),
    .mem_rtrn_type_i ( mem_rtrn_type_i ),
    .arr             ( arr.ctrl        )
  );

  icache_tag_array i_tag_array (
    .clk_i  ( clk_i      ),
    .rst_ni ( rst_ni     ),
    .rtrn_i ( mem_rtrn_i ),
    .arr    ( arr.tag    )
  );

  icache_data_array i_data_array (
    .clk_i  ( clk_i      ),
    .rtrn_i ( mem_rtrn_i ),
    .data_o ( data_o     ),
    .arr    ( arr.data   )
  );

  icache_repl #(
    .LfsrSeed ( LfsrSeed )
  ) i_repl (
    .clk_i  ( clk_i    ),
    .rst_ni ( rst_ni   ),
    .arr    ( arr.repl )
  );

endmodule

// File: tb.f
icache_cfg_pkg.sv
icache_mem_pkg.sv
icache_array_if.sv
icache_ctrl.sv
icache_tag_array.sv
icache_data_array.sv
icache_repl.sv
icache_top.sv
tb_icache.sv

// File: tb_icache.sv
////////////////////////////////////////////////////////////////////////////
// directed testbench for the instruction cache top level
// the memory model returns byte address ^ 32'h5a5a0000 for every word
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_icache;

  localparam int unsigned MaxCycles    = 3000;
  localparam int unsigned NumSets      = icache_cfg_pkg::NumSets;
  localparam int unsigned WordsPerLine = icache_cfg_pkg::LineWidth / icache_cfg_pkg::FetchWidth;
  // tag 0x000012, set 3, word 1
  localparam icache_cfg_pkg::addr_t LineA = 32'h0000_1234;

  logic                          clk_i = 1'b0;
  logic                          rst_ni;
  logic                          en_i;
  logic                          flush_i;
  logic                          req_i;
  icache_cfg_pkg::addr_t         addr_i;
  logic                          ready_o;
  logic                          valid_o;
  icache_cfg_pkg::fetch_t        data_o;
  icache_cfg_pkg::addr_t         addr_o;
  logic                          miss_o;
  logic                          mem_req_o;
  logic                          mem_ack_i;
  icache_cfg_pkg::addr_t         mem_addr_o;
  logic                          mem_nc_o;
  icache_cfg_pkg::way_idx_t      mem_way_o;
  logic                          mem_rtrn_vld_i;
  icache_mem_pkg::rtrn_type_e    mem_rtrn_type_i;
  icache_mem_pkg::rtrn_payload_u mem_rtrn_i;

  integer                seed = 32'hec16f423;
  int unsigned           cycle_cnt = 0;
  int unsigned           err_cnt = 0;
  int unsigned           check_cnt = 0;
  int unsigned           test_cnt = 0;
  // addresses for the next back-to-back hit burst
  icache_cfg_pkg::addr_t burst_q[$];

  always #10 clk_i = ~clk_i;

  icache_top #(
    .LfsrSeed ( 4'h9 )
  ) i_dut (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .en_i            ( en_i            ),
    .flush_i         ( flush_i         ),
    .req_i           ( req_i           ),
    .addr_i          ( addr_i          ),
    .ready_o         ( ready_o         ),
    .valid_o         ( valid_o         ),
    .data_o          ( data_o          ),
    .addr_o          ( addr_o          ),
    .miss_o          ( miss_o          ),
    .mem_req_o       ( mem_req_o       ),
    .mem_ack_i       ( mem_ack_i       ),
    .mem_addr_o      ( mem_addr_o      ),
    .mem_nc_o        ( mem_nc_o        ),
    .mem_way_o       ( mem_way_o       ),
    .mem_rtrn_vld_i  ( mem_rtrn_vld_i  ),
    .mem_rtrn_type_i ( mem_rtrn_type_i ),
    .mem_rtrn_i      ( mem_rtrn_i      )
  );

  ////////////////////////////////////////////////////////////////////////////
  // reference rules and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  // word that memory holds at a byte address
  function automatic icache_cfg_pkg::fetch_t rule_word(input icache_cfg_pkg::addr_t addr);
    return (addr & ~icache_cfg_pkg::addr_t'(3)) ^ 32'h5a5a0000;
  endfunction

  function automatic icache_cfg_pkg::addr_t make_addr(input int tag, input int set,
                                                      input int word);
    return {icache_cfg_pkg::tag_t'(tag), icache_cfg_pkg::set_idx_t'(set), 2'(word), 2'b00};
  endfunction

  task automatic check_fetch(input string name, input icache_cfg_pkg::fetch_t got,
                             input icache_cfg_pkg::fetch_t exp);
    check_cnt++;
    if (got !== exp) begin
      $display("FAIL %0t %s: got %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_addr(input string name, input icache_cfg_pkg::addr_t got,
                            input icache_cfg_pkg::addr_t exp);
    check_cnt++;
    if (got !== exp) begin
      $display("FAIL %0t %s: got %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_way(input string name, input icache_cfg_pkg::way_idx_t got,
                           input icache_cfg_pkg::way_idx_t exp);
    check_cnt++;
    if (got !== exp) begin
      $display("FAIL %0t %s: got %0d, expected %0d", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      $display("FAIL %0t %s: got %b, expected %b", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int unsigned errs_before);
    test_cnt++;
    $display("test %s finished with %0d errors", name, err_cnt - errs_before);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // memory model and stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  // ack 0 to 3 cycles after the request is seen, return 1 to 4 cycles after ack
  initial begin : memory_model
    icache_cfg_pkg::addr_t         base;
    icache_mem_pkg::rtrn_payload_u line;
    int unsigned                   delay;
    forever begin
      @(negedge clk_i);
      if (rst_ni && mem_req_o) begin
        delay = {$random(seed)} % 4;
        repeat (delay) @(negedge clk_i);
        // uncached requests still get the whole surrounding line
        base = mem_addr_o & ~icache_cfg_pkg::addr_t'(15);
        @(posedge clk_i);
        mem_ack_i <= 1'b1;
        @(posedge clk_i);
        mem_ack_i <= 1'b0;
        delay = {$random(seed)} % 4;
        repeat (delay) @(posedge clk_i);
        for (int i = 0; i < WordsPerLine; i++) begin
          line.data[i*32 +: 32] = rule_word(base + 4 * i);
        end
        mem_rtrn_vld_i  <= 1'b1;
        mem_rtrn_type_i <= icache_mem_pkg::ICACHE_IFILL_ACK;
        mem_rtrn_i      <= line;
        @(posedge clk_i);
        mem_rtrn_vld_i  <= 1'b0;
      end
    end
  end

  // ready_o low while the cache flushes, then high
  task automatic expect_flush(input int unsigned busy_cycles);
    for (int unsigned k = 0; k < busy_cycles; k++) begin
      @(negedge clk_i);
      check_flag("ready_o", ready_o, 1'b0);
    end
    @(negedge clk_i);
    check_flag("ready_o", ready_o, 1'b1);
  endtask

  // one fetch that must go to memory, optionally checking the refill way
  task automatic fetch_miss(input icache_cfg_pkg::addr_t addr, input logic exp_nc,
                            input logic chk_way, input icache_cfg_pkg::way_idx_t exp_way);
    int unsigned              acks;
    logic                     seen_miss;
    icache_cfg_pkg::addr_t    req_addr;
    logic                     req_nc;
    icache_cfg_pkg::way_idx_t fill_way;
    @(posedge clk_i);
    req_i  <= 1'b1;
    addr_i <= addr;
    @(negedge clk_i);
    while (!ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    req_i     <= 1'b0;
    acks      = 0;
    seen_miss = 1'b0;
    @(negedge clk_i);
    while (!valid_o) begin
      if (mem_req_o && mem_ack_i) begin
        acks++;
        req_addr = mem_addr_o;
        req_nc   = mem_nc_o;
      end
      if (miss_o) begin
        seen_miss = 1'b1;
      end
      @(negedge clk_i);
    end
    fill_way = mem_way_o;
    if (acks != 1) begin
      $display("error at %0t: fetch of %h made %0d memory requests instead of one",
               $time, addr, acks);
      err_cnt++;
    end else begin
      check_addr("mem_addr_o", req_addr,
                 addr & ~icache_cfg_pkg::addr_t'(exp_nc ? 3 : 15));
      check_flag("mem_nc_o", req_nc, exp_nc);
    end
    check_flag("miss_o", seen_miss, !exp_nc);
    check_fetch("data_o", data_o, rule_word(addr));
    check_addr("addr_o", addr_o, addr);
    if (chk_way) begin
      check_way("mem_way_o", fill_way, exp_way);
    end
  endtask

  // back-to-back fetches from burst_q, each valid one cycle after acceptance
  task automatic fetch_hits();
    icache_cfg_pkg::addr_t addr;
    @(posedge clk_i);
    req_i  <= 1'b1;
    addr_i <= burst_q[0];
    @(negedge clk_i);
    while (!ready_o) begin
      @(negedge clk_i);
    end
    while (burst_q.size() > 0) begin
      addr = burst_q.pop_front();
      // this edge accepts addr
      @(posedge clk_i);
      if (burst_q.size() > 0) begin
        addr_i <= burst_q[0];
      end else begin
        req_i <= 1'b0;
      end
      @(negedge clk_i);
      check_flag("valid_o", valid_o, 1'b1);
      check_fetch("data_o", data_o, rule_word(addr));
      check_addr("addr_o", addr_o, addr);
      check_flag("mem_req_o", mem_req_o, 1'b0);
      if (burst_q.size() > 0) begin
        check_flag("ready_o", ready_o, 1'b1);
      end
    end
  endtask

  // invalidation on the return port while the cache is idle
  task automatic send_inv(input int set, input int way, input logic one_way,
                          input logic all_ways);
    icache_mem_pkg::rtrn_payload_u pl;
    pl              = '0;
    pl.inv.idx      = icache_cfg_pkg::set_idx_t'(set);
    pl.inv.way      = icache_cfg_pkg::way_idx_t'(way);
    pl.inv.one_way  = one_way;
    pl.inv.all_ways = all_ways;
    @(posedge clk_i);
    mem_rtrn_vld_i  <= 1'b1;
    mem_rtrn_type_i <= icache_mem_pkg::ICACHE_INV_REQ;
    mem_rtrn_i      <= pl;
    @(negedge clk_i);
    check_flag("ready_o", ready_o, 1'b0);
    @(posedge clk_i);
    mem_rtrn_vld_i  <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic cold_miss();
    int unsigned errs;
    errs = err_cnt;
    expect_flush(NumSets);
    fetch_miss(LineA, 1'b0, 1'b1, 2'd0);
    report_test("cold_miss", errs);
  endtask

  task automatic hit_lines();
    int unsigned errs;
    errs = err_cnt;
    burst_q.push_back(32'h0000_1238);
    fetch_hits();
    burst_q.push_back(32'h0000_123c);
    burst_q.push_back(32'h0000_1230);
    burst_q.push_back(32'h0000_1234);
    burst_q.push_back(32'h0000_1238);
    fetch_hits();
    report_test("hit_lines", errs);
  endtask

  // set 5 fills ways in order, a fifth tag evicts one of them
  task automatic replace_ways();
    int unsigned errs;
    errs = err_cnt;
    for (int k = 0; k < 4; k++) begin
      fetch_miss(make_addr(32'h100 + k, 5, k), 1'b0, 1'b1, 2'(k));
    end
    for (int k = 0; k < 4; k++) begin
      burst_q.push_back(make_addr(32'h100 + k, 5, 3));
    end
    fetch_hits();
    fetch_miss(make_addr(32'h200, 5, 0), 1'b0, 1'b0, 2'd0);
    burst_q.push_back(make_addr(32'h200, 5, 1));
    fetch_hits();
    report_test("replace_ways", errs);
  endtask

  task automatic invalidate_set();
    int unsigned errs;
    errs = err_cnt;
    for (int k = 0; k < 4; k++) begin
      fetch_miss(make_addr(32'h300 + k, 9, 0), 1'b0, 1'b1, 2'(k));
    end
    // drop way 2 only, its refill takes the freed way
    send_inv(9, 2, 1'b1, 1'b0);
    burst_q.push_back(make_addr(32'h300, 9, 1));
    burst_q.push_back(make_addr(32'h301, 9, 1));
    burst_q.push_back(make_addr(32'h303, 9, 1));
    fetch_hits();
    fetch_miss(make_addr(32'h302, 9, 2), 1'b0, 1'b1, 2'd2);
    send_inv(9, 0, 1'b0, 1'b1);
    for (int k = 0; k < 4; k++) begin
      fetch_miss(make_addr(32'h300 + k, 9, 3), 1'b0, 1'b1, 2'(k));
    end
    report_test("invalidate_set", errs);
  endtask

  task automatic flush_all();
    int unsigned errs;
    errs = err_cnt;
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(negedge clk_i);
    check_flag("ready_o", ready_o, 1'b0);
    @(posedge clk_i);
    flush_i <= 1'b0;
    expect_flush(NumSets);
    fetch_miss(LineA, 1'b0, 1'b1, 2'd0);
    fetch_miss(make_addr(32'h200, 5, 0), 1'b0, 1'b1, 2'd0);
    for (int k = 0; k < 4; k++) begin
      fetch_miss(make_addr(32'h300 + k, 9, 0), 1'b0, 1'b1, 2'(k));
    end
    report_test("flush_all", errs);
  endtask

  // uncached word fetches, then re-enable through a flush
  task automatic disabled_cache();
    int unsigned           errs;
    icache_cfg_pkg::addr_t nc_addr;
    errs    = err_cnt;
    nc_addr = make_addr(32'h400, 7, 2);
    @(posedge clk_i);
    en_i <= 1'b0;
    fetch_miss(nc_addr, 1'b1, 1'b0, 2'd0);
    fetch_miss(nc_addr, 1'b1, 1'b0, 2'd0);
    @(posedge clk_i);
    en_i <= 1'b1;
    expect_flush(NumSets + 1);
    fetch_miss(nc_addr, 1'b0, 1'b1, 2'd0);
    burst_q.push_back(nc_addr);
    fetch_hits();
    report_test("disabled_cache", errs);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sequence and timeout
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    rst_ni          = 1'b0;
    en_i            = 1'b1;
    flush_i         = 1'b0;
    req_i           = 1'b0;
    addr_i          = '0;
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_type_i = icache_mem_pkg::ICACHE_IFILL_ACK;
    mem_rtrn_i      = '0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    cold_miss();
    hit_lines();
    replace_ways();
    invalidate_set();
    flush_all();
    disabled_cache();
    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= MaxCycles) begin
      $display("timeout: tests did not complete within %0d cycles", MaxCycles);
      $display("Simulation failed");
      $finish;
    end
  end

endmodule
